// ==== src/csa_pkg.sv ====
`default_nettype none

package csa_pkg;

	// ----------------------------------------
	// Word geometry
	// ----------------------------------------
	localparam int in_width        = 32;
	localparam int out_width       = 40;
	localparam int group_in_words  = 5;
	localparam int group_bits      = in_width * group_in_words;  // 160
	localparam int group_out_words = group_bits / out_width;

	// ----------------------------------------
	// FIFO sizes
	// ----------------------------------------
	localparam int in_depth    = 16;
	localparam int out_depth   = 16;
	localparam int count_width = 5;  // Holds a count of 16

	// Gearbox state encoding
	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_read  = 2'd1;
	localparam logic [1:0] st_pack  = 2'd2;
	localparam logic [1:0] st_write = 2'd3;

	// Fill level and error flags of one FIFO
	typedef struct packed {
		logic [count_width-1:0] count;
		logic                   ready;      // count at or above threshold
		logic                   overflow;   // Sticky
		logic                   underflow;  // Sticky
	} fifo_status_t;

	// One group, seen as five input words or as four output words
	typedef union packed {
		logic [group_in_words-1:0][in_width-1:0]   words_in;
		logic [group_out_words-1:0][out_width-1:0] words_out;
	} gear_buf_u;

endpackage

`default_nettype wire

// ==== src/word_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_fifo import csa_pkg::*; #(
	parameter int width       = 32,
	parameter int depth       = 16,
	parameter int ready_level = 1
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              wen,
	input  wire [width-1:0]  wdata,
	input  wire              ren,
	output logic [width-1:0] rdata,
	output logic             full,
	output fifo_status_t     status
);

	logic [width-1:0]         mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [count_width-1:0]   count;
	logic                     empty;
	logic                     do_write;
	logic                     do_read;
	logic                     overflow;
	logic                     underflow;

	// Pointer step with wrap at depth
	function automatic logic [$clog2(depth)-1:0] ptr_inc(
		input logic [$clog2(depth)-1:0] ptr
	);
		return (ptr == depth - 1) ? '0 : ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign full     = (count == depth);
	assign do_write = wen && !full;   // Write to full is dropped
	assign do_read  = ren && !empty;  // Read from empty is ignored

	// ----------------------------------------
	// Storage and read port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (do_read) begin
			rdata <= mem[rd_ptr];  // Holds last word otherwise
		end
	end

	// ----------------------------------------
	// Pointers and fill level
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: begin
				end
			endcase
		end
	end

	// Error flags, cleared by reset only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			if (wen && full) begin
				overflow <= 1'b1;
			end
			if (ren && empty) begin
				underflow <= 1'b1;
			end
		end
	end

	assign status = '{
		count:     count,
		ready:     (count >= ready_level),
		overflow:  overflow,
		underflow: underflow
	};

	a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= depth)
		else $error("word_fifo count %0d above depth %0d", count, depth);

endmodule

`default_nettype wire

// ==== src/gearbox_32_to_40.sv ====
`timescale 1ns/10ps
`default_nettype none

module gearbox_32_to_40 import csa_pkg::*; (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  src_ready,
	output logic                 src_ren,
	input  wire [in_width-1:0]   src_rdata,
	input  wire                  dst_full,
	output logic                 dst_wen,
	output logic [out_width-1:0] dst_wdata
);

	logic [1:0]                                state;
	logic [$clog2(group_in_words+1)-1:0]       ren_cnt;    // Reads issued this group
	logic [$clog2(group_in_words)-1:0]         cap_idx;    // Next slot to fill
	logic                                      cap_valid;  // src_rdata carries a word
	logic [$clog2(group_out_words)-1:0]        wr_idx;     // Next output word
	gear_buf_u                                 buffer;
	logic [group_out_words-1:0][out_width-1:0] hold;

	// ----------------------------------------
	// Handshake outputs
	// ----------------------------------------
	assign src_ren   = (state == st_read) && (ren_cnt < group_in_words);
	assign dst_wen   = (state == st_write) && !dst_full;
	assign dst_wdata = hold[wr_idx];

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= st_idle;
			ren_cnt   <= '0;
			cap_idx   <= '0;
			cap_valid <= 1'b0;
			wr_idx    <= '0;
		end else begin
			cap_valid <= src_ren;  // Word arrives one cycle after ren
			case (state)
				st_idle: begin
					if (src_ready) begin
						ren_cnt <= '0;
						cap_idx <= '0;
						state   <= st_read;
					end
				end
				st_read: begin
					if (src_ren) begin
						ren_cnt <= ren_cnt + 1'b1;
					end
					if (cap_valid) begin
						if (cap_idx == group_in_words - 1) begin
							state <= st_pack;  // Last word taken
						end else begin
							cap_idx <= cap_idx + 1'b1;
						end
					end
				end
				st_pack: begin
					wr_idx <= '0;
					state  <= st_write;
				end
				st_write: begin
					// Stays here while the output FIFO is full
					if (dst_wen) begin
						wr_idx <= wr_idx + 1'b1;
						if (wr_idx == group_out_words - 1) begin
							state <= st_idle;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ----------------------------------------
	// Group buffer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cap_valid) begin
			buffer.words_in[cap_idx] <= src_rdata;  // Word k into slot k
		end
		if (state == st_pack) begin
			hold <= buffer.words_out;
		end
	end

	// Five back-to-back reads inside the read state, then one capture cycle
	a_read_burst: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(src_ren) |->
			(src_ren && state == st_read) [*group_in_words]
			##1 (!src_ren && state == st_read))
		else $error("gearbox read burst broken");

	// No write into a full FIFO, and the pending word waits in place
	a_hold_on_full: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_write && dst_full) |->
			!dst_wen ##1 (state == st_write && $stable(wr_idx)))
		else $error("gearbox wrote or moved on while output FIFO full");

endmodule

`default_nettype wire

// ==== src/csa_in_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module csa_in_bridge import csa_pkg::*; (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_wen,
	input  wire [in_width-1:0]   in_wdata,
	output fifo_status_t         in_status,
	input  wire                  out_ren,
	output logic [out_width-1:0] out_rdata,
	output fifo_status_t         out_status
);

	logic                 gear_ren;
	logic [in_width-1:0]  gear_rdata;
	logic                 gear_wen;
	logic [out_width-1:0] gear_wdata;
	logic                 out_full;

	// ----------------------------------------
	// 32-bit side
	// ----------------------------------------
	word_fifo #(
		.width       (in_width),
		.depth       (in_depth),
		.ready_level (group_in_words)  // A full group is waiting
	) u_in_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.wen    (in_wen),
		.wdata  (in_wdata),
		.ren    (gear_ren),
		.rdata  (gear_rdata),
		.full   (),                    // Producer watches in_status.count
		.status (in_status)
	);

	gearbox_32_to_40 u_gearbox (
		.clk       (clk),
		.rst_n     (rst_n),
		.src_ready (in_status.ready),
		.src_ren   (gear_ren),
		.src_rdata (gear_rdata),
		.dst_full  (out_full),
		.dst_wen   (gear_wen),
		.dst_wdata (gear_wdata)
	);

	// ----------------------------------------
	// 40-bit side
	// ----------------------------------------
	word_fifo #(
		.width       (out_width),
		.depth       (out_depth),
		.ready_level (1)
	) u_out_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.wen    (gear_wen),
		.wdata  (gear_wdata),
		.ren    (out_ren),
		.rdata  (out_rdata),
		.full   (out_full),
		.status (out_status)
	);

endmodule

`default_nettype wire

// ==== test/tb_csa_in_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_csa_in_bridge import csa_pkg::*; ();

	typedef logic [group_out_words-1:0][out_width-1:0] out_group_t;

	logic                 clk;
	logic                 rst_n;
	logic                 in_wen;
	logic [in_width-1:0]  in_wdata;
	fifo_status_t         in_status;
	logic                 out_ren = 1'b0;
	logic [out_width-1:0] out_rdata;
	fifo_status_t         out_status;

	logic                 read_enable;
	logic                 empty_read;          // Stray read into an empty FIFO
	logic                 empty_read_q = 1'b0;
	logic                 checking = 1'b0;     // out_rdata holds a word to compare
	string                test_name;
	int                   errors;
	int                   timeouts;
	int                   words_checked;
	int                   start_count;
	int                   i;
	int unsigned          seed;
	logic [out_width-1:0] exp_word;
	logic [out_width-1:0] last_rdata;
	logic [in_width-1:0]  group_words[$];      // Accepted words of the open group
	logic [out_width-1:0] expected[$];

	csa_in_bridge u_csa_in_bridge (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_wen     (in_wen),
		.in_wdata   (in_wdata),
		.in_status  (in_status),
		.out_ren    (out_ren),
		.out_rdata  (out_rdata),
		.out_status (out_status)
	);

	always #4 clk = ~clk;  // 8 ns period

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	// Word 0 in the least significant bits on both sides
	function automatic out_group_t pack_group(
		input logic [in_width-1:0] w0,
		input logic [in_width-1:0] w1,
		input logic [in_width-1:0] w2,
		input logic [in_width-1:0] w3,
		input logic [in_width-1:0] w4
	);
		logic [group_bits-1:0] bits;
		out_group_t            result;
		int                    k;
		bits = {w4, w3, w2, w1, w0};
		for (k = 0; k < group_out_words; k++) begin
			result[k] = bits[k*out_width +: out_width];
		end
		return result;
	endfunction

	task automatic queue_word(input logic [in_width-1:0] word);
		out_group_t grp;
		int         k;
		group_words.push_back(word);
		if (group_words.size() == group_in_words) begin
			grp = pack_group(group_words[0], group_words[1], group_words[2],
				group_words[3], group_words[4]);
			for (k = 0; k < group_out_words; k++) begin
				expected.push_back(grp[k]);
			end
			group_words.delete();
		end
	endtask

	// ----------------------------------------
	// Producer side
	// ----------------------------------------
	task automatic write_word(input logic [in_width-1:0] word);
		int waited;
		waited = 0;
		@(negedge clk);
		while (in_status.count == in_depth && waited < 2000) begin
			@(negedge clk);
			waited++;
		end
		if (in_status.count == in_depth) begin
			timeouts++;
			$display("Timeout in %s: input FIFO never left the full state", test_name);
		end else begin
			@(posedge clk);
			in_wen   <= 1'b1;
			in_wdata <= word;
			queue_word(word);
			@(posedge clk);
			in_wen <= 1'b0;  // One idle cycle so count is current at next check
		end
	endtask

	// Write regardless of fill level, word is not expected back
	task automatic drop_word(input logic [in_width-1:0] word);
		@(posedge clk);
		in_wen   <= 1'b1;
		in_wdata <= word;
		@(posedge clk);
		in_wen <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic set_reading(input logic on);
		@(posedge clk);
		read_enable <= on;
	endtask

	// ----------------------------------------
	// Bounded waits
	// ----------------------------------------
	task automatic wait_out_count(input int target, input int limit, input string what);
		int waited;
		waited = 0;
		@(negedge clk);
		while (out_status.count != target && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (out_status.count != target) begin
			timeouts++;
			$display("Timeout in %s: %s", test_name, what);
		end
	endtask

	task automatic wait_in_count(input int target, input int limit, input string what);
		int waited;
		waited = 0;
		@(negedge clk);
		while (in_status.count != target && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (in_status.count != target) begin
			timeouts++;
			$display("Timeout in %s: %s", test_name, what);
		end
	endtask

	task automatic wait_drained(input int limit);
		int waited;
		waited = 0;
		@(negedge clk);
		while ((expected.size() != 0 || out_status.count != 0) && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (expected.size() != 0 || out_status.count != 0) begin
			timeouts++;
			$display("Timeout in %s: %0d expected output words never came out",
				test_name, expected.size());
		end
	endtask

	task automatic check_value(input string what, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		assert (act_val === exp_val) else begin
			errors++;
			$display("FAILED %s: %s expected %0h, actual %0h",
				test_name, what, exp_val, act_val);
		end
	endtask

	// ----------------------------------------
	// Consumer and checker
	// ----------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			out_ren      <= 1'b0;
			empty_read_q <= 1'b0;
			checking     <= 1'b0;
		end else begin
			empty_read_q <= empty_read;
			checking     <= out_ren && !empty_read_q;
			out_ren      <= empty_read ||
				(read_enable && !out_ren && out_status.count != 0);  // Every other cycle
		end
	end

	always @(negedge clk) begin
		if (checking) begin
			words_checked++;
			assert (expected.size() != 0) else begin
				errors++;
				$display("Output word %0h in %s arrived with nothing left to expect",
					out_rdata, test_name);
			end
			if (expected.size() != 0) begin
				exp_word = expected.pop_front();
				assert (out_rdata === exp_word) else begin
					errors++;
					$display("FAILED %s: expected %h, actual %h",
						test_name, exp_word, out_rdata);
				end
			end
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		seed          = 32'hd73e_63d6;
		void'($urandom(seed));
		clk           = 1'b0;
		rst_n         = 1'b0;
		in_wen        = 1'b0;
		in_wdata      = '0;
		read_enable   = 1'b0;
		empty_read    = 1'b0;
		errors        = 0;
		timeouts      = 0;
		words_checked = 0;
		test_name     = "reset";
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_value("in_status", 64'(0), 64'(in_status));
		check_value("out_status", 64'(0), 64'(out_status));
		check_value("out_rdata", 64'(0), 64'(out_rdata));

		test_name = "random_stream";
		set_reading(1'b1);
		start_count = words_checked;
		for (i = 0; i < 40 * group_in_words; i++) begin
			write_word($urandom);
			idle_cycles($urandom_range(0, 3));
		end
		wait_drained(4000);
		idle_cycles(20);
		check_value("output words", 64'(160), 64'(words_checked - start_count));

		// Output FIFO fills, then one group stalls inside the gearbox
		test_name = "back_pressure";
		set_reading(1'b0);
		for (i = 0; i < 5 * group_in_words; i++) begin
			write_word($urandom);
		end
		wait_out_count(out_depth, 500, "output FIFO never filled");
		wait_in_count(0, 500, "gearbox never took the stalled group");
		idle_cycles(30);
		@(negedge clk);
		check_value("out count", 64'(out_depth), 64'(out_status.count));
		check_value("out overflow", 64'(0), 64'(out_status.overflow));

		test_name = "input_overflow";
		for (i = 0; i < in_depth; i++) begin
			write_word($urandom);
		end
		@(negedge clk);
		check_value("in count", 64'(in_depth), 64'(in_status.count));
		check_value("in ready", 64'(1), 64'(in_status.ready));
		check_value("in overflow before drop", 64'(0), 64'(in_status.overflow));
		drop_word($urandom);
		@(negedge clk);
		check_value("in overflow", 64'(1), 64'(in_status.overflow));
		check_value("in count after drop", 64'(in_depth), 64'(in_status.count));

		test_name = "resume_after_stall";
		set_reading(1'b1);
		for (i = 0; i < 4; i++) begin
			write_word($urandom);  // Completes the last open group
		end
		wait_drained(2000);
		check_value("out overflow", 64'(0), 64'(out_status.overflow));

		test_name = "partial_group";
		set_reading(1'b0);
		for (i = 0; i < 3; i++) begin
			write_word($urandom);
		end
		idle_cycles(50);
		@(negedge clk);
		check_value("out count", 64'(0), 64'(out_status.count));
		check_value("in count", 64'(3), 64'(in_status.count));
		check_value("in ready", 64'(0), 64'(in_status.ready));
		for (i = 0; i < 2; i++) begin
			write_word($urandom);
		end
		wait_out_count(group_out_words, 200, "completed group never reached the output");
		idle_cycles(20);
		@(negedge clk);
		check_value("out count", 64'(group_out_words), 64'(out_status.count));
		check_value("out ready", 64'(1), 64'(out_status.ready));
		check_value("in count", 64'(0), 64'(in_status.count));
		set_reading(1'b1);
		wait_drained(500);

		test_name = "output_underflow";
		set_reading(1'b0);
		idle_cycles(4);
		@(negedge clk);
		last_rdata = out_rdata;
		check_value("out underflow before read", 64'(0), 64'(out_status.underflow));
		@(posedge clk);
		empty_read <= 1'b1;
		@(posedge clk);
		empty_read <= 1'b0;
		idle_cycles(4);
		@(negedge clk);
		check_value("out underflow", 64'(1), 64'(out_status.underflow));
		check_value("out_rdata", 64'(last_rdata), 64'(out_rdata));
		check_value("in underflow", 64'(0), 64'(in_status.underflow));

		$display("Summary: %0d errors, %0d timeouts, %0d output words checked",
			errors, timeouts, words_checked);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/csa_pkg.sv
src/word_fifo.sv
src/gearbox_32_to_40.sv
src/csa_in_bridge.sv
test/tb_csa_in_bridge.sv

// ==== Makefile ====
# Verilator build and run for the csa_in_bridge testbench

VERILATOR  ?= verilator
TOP        ?= tb_csa_in_bridge
RTL_TOP    ?= csa_in_bridge
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= Test passed
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= src/csa_pkg.sv src/word_fifo.sv src/gearbox_32_to_40.sv src/csa_in_bridge.sv

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
